// ==== rt_pkg.sv ====
package rt_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int COORD_W = 16;
  localparam int EDGE_W  = 17;  // Difference of two coordinates
  localparam int CROSS_W = 36;
  localparam int DOT_W   = 56;
  localparam int SID_W   = 32;
  localparam int ID_W    = 16;  // Widest id the top level can be built with

  typedef struct packed {
    logic signed [COORD_W-1:0] x;
    logic signed [COORD_W-1:0] y;
    logic signed [COORD_W-1:0] z;
  } coord_vec_t;

  typedef struct packed {
    logic signed [EDGE_W-1:0] x;
    logic signed [EDGE_W-1:0] y;
    logic signed [EDGE_W-1:0] z;
  } edge_vec_t;

  typedef struct packed {
    logic signed [CROSS_W-1:0] x;
    logic signed [CROSS_W-1:0] y;
    logic signed [CROSS_W-1:0] z;
  } cross_vec_t;

  // The six products of a cross product, before the pairs are subtracted
  typedef struct packed {
    logic signed [CROSS_W-1:0] yz;
    logic signed [CROSS_W-1:0] zy;
    logic signed [CROSS_W-1:0] zx;
    logic signed [CROSS_W-1:0] xz;
    logic signed [CROSS_W-1:0] xy;
    logic signed [CROSS_W-1:0] yx;
  } cross_part_t;

  typedef struct packed {
    logic [SID_W-1:0] sid;
    logic [ID_W-1:0]  thread_id;
    logic [ID_W-1:0]  triangle_id;
  } tag_t;

  // ========================================
  // Stage payloads
  // ========================================
  typedef struct packed {
    coord_vec_t origin;
    coord_vec_t dir;
    coord_vec_t v0;
    coord_vec_t v1;
    coord_vec_t v2;
    tag_t       tag;
  } ray_tri_t;

  typedef struct packed {
    edge_vec_t  e1;
    edge_vec_t  e2;
    edge_vec_t  tvec;
    coord_vec_t dir;
    tag_t       tag;
  } edge_pl_t;

  typedef struct packed {
    edge_vec_t  e1;
    edge_vec_t  e2;
    edge_vec_t  tvec;
    coord_vec_t dir;  // Still needed for v_num in the last stage
    cross_vec_t pvec;
    cross_vec_t qvec;
    tag_t       tag;
  } cross_pl_t;

  typedef struct packed {
    logic                    hit;
    logic signed [DOT_W-1:0] det;
    logic signed [DOT_W-1:0] t_num;
    logic signed [DOT_W-1:0] u_num;
    logic signed [DOT_W-1:0] v_num;
    tag_t                    tag;
  } hit_result_t;

  // ========================================
  // Vector helpers
  // ========================================
  function automatic edge_vec_t ext_vec(input coord_vec_t a);
    edge_vec_t r;
    r.x = a.x;
    r.y = a.y;
    r.z = a.z;
    return r;
  endfunction

  function automatic edge_vec_t sub_vec(input coord_vec_t a, input coord_vec_t b);
    edge_vec_t r;
    r.x = a.x - b.x;
    r.y = a.y - b.y;
    r.z = a.z - b.z;
    return r;
  endfunction

  function automatic cross_part_t cross_parts(input edge_vec_t a, input edge_vec_t b);
    cross_part_t r;
    r.yz = a.y * b.z;
    r.zy = a.z * b.y;
    r.zx = a.z * b.x;
    r.xz = a.x * b.z;
    r.xy = a.x * b.y;
    r.yx = a.y * b.x;
    return r;
  endfunction

  // Finishes a cross product from its registered partial products
  function automatic cross_vec_t cross_vec(input cross_part_t p);
    cross_vec_t r;
    r.x = p.yz - p.zy;
    r.y = p.zx - p.xz;
    r.z = p.xy - p.yx;
    return r;
  endfunction

  function automatic logic signed [DOT_W-1:0] dot_vec(input edge_vec_t a, input cross_vec_t b);
    return a.x * b.x + a.y * b.y + a.z * b.z;
  endfunction

endpackage

// ==== rt_stage_reg.sv ====
module rt_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     done,
  input  logic     next_capture,
  input  payload_t data_in,
  output logic     capture,
  output payload_t data_out
);

  // CAP means the slot downstream is free and no done is pending yet,
  // DONE means a done is pending and the slot downstream is still busy
  typedef enum logic [1:0] {DONE, CAP, LOAD, IDLE} state_t;

  state_t   state;
  state_t   nxt_state;
  logic     ld;
  payload_t data_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= CAP;
    end else begin
      state <= nxt_state;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_q <= '0;
    end else if (ld) begin
      data_q <= data_in;
    end
  end

  // ========================================
  // Next state
  // ========================================
  always_comb begin
    ld        = 1'b0;
    capture   = 1'b0;
    nxt_state = IDLE;
    case (state)
      CAP: begin
        if (done) begin
          ld        = 1'b1;
          nxt_state = LOAD;
        end else begin
          nxt_state = CAP;
        end
      end
      DONE: begin
        if (next_capture) begin
          ld        = 1'b1;
          nxt_state = LOAD;
        end else begin
          nxt_state = DONE;
        end
      end
      default: begin
        // LOAD behaves like IDLE, so a take in the same cycle as capture is kept
        capture = (state == LOAD);
        if (done && next_capture) begin
          ld        = 1'b1;
          nxt_state = LOAD;
        end else if (next_capture) begin
          nxt_state = CAP;
        end else if (done) begin
          nxt_state = DONE;
        end
      end
    endcase
  end

  assign data_out = data_q;

endmodule

// ==== rt_edge_setup.sv ====
module rt_edge_setup (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  rt_pkg::ray_tri_t src,
  output logic             done,
  output rt_pkg::edge_pl_t result
);

  rt_pkg::edge_vec_t e1;
  rt_pkg::edge_vec_t e2;
  rt_pkg::edge_vec_t tvec;

  // Both edges share v0 as their base
  assign e1   = rt_pkg::sub_vec(src.v1, src.v0);
  assign e2   = rt_pkg::sub_vec(src.v2, src.v0);
  assign tvec = rt_pkg::sub_vec(src.origin, src.v0);  // Origin seen from v0

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= start;
      if (start) begin
        result.e1   <= e1;
        result.e2   <= e2;
        result.tvec <= tvec;
        result.dir  <= src.dir;
        result.tag  <= src.tag;
      end
    end
  end

endmodule

// ==== rt_cross_stage.sv ====
module rt_cross_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  rt_pkg::edge_pl_t  src,
  output logic              done,
  output rt_pkg::cross_pl_t result
);

  logic [1:0]          start_sr;  // One bit per cycle of the multiply pipeline
  rt_pkg::edge_pl_t    src_q;
  rt_pkg::cross_part_t p_part;
  rt_pkg::cross_part_t q_part;

  // ========================================
  // Cycle 1, partial products
  // ========================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_sr <= '0;
      src_q    <= '0;
      p_part   <= '0;
      q_part   <= '0;
    end else begin
      start_sr <= {start_sr[0], start};
      if (start) begin
        src_q  <= src;
        p_part <= rt_pkg::cross_parts(rt_pkg::ext_vec(src.dir), src.e2);  // pvec = dir x e2
        q_part <= rt_pkg::cross_parts(src.tvec, src.e1);                  // qvec = tvec x e1
      end
    end
  end

  // ========================================
  // Cycle 2, subtract the pairs
  // ========================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result <= '0;
    end else if (start_sr[0]) begin
      result.e1   <= src_q.e1;
      result.e2   <= src_q.e2;
      result.tvec <= src_q.tvec;
      result.dir  <= src_q.dir;
      result.pvec <= rt_pkg::cross_vec(p_part);
      result.qvec <= rt_pkg::cross_vec(q_part);
      result.tag  <= src_q.tag;
    end
  end

  assign done = start_sr[1];

endmodule

// ==== rt_hit_test.sv ====
module rt_hit_test (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  rt_pkg::cross_pl_t   src,
  output logic                done,
  output rt_pkg::hit_result_t result
);

  logic signed [rt_pkg::DOT_W-1:0] det;
  logic signed [rt_pkg::DOT_W-1:0] u_num;
  logic signed [rt_pkg::DOT_W-1:0] v_num;
  logic signed [rt_pkg::DOT_W-1:0] t_num;
  logic signed [rt_pkg::DOT_W:0]   uv_sum;  // One bit wider so the sum cannot wrap
  logic                            hit;

  // ========================================
  // Dot products
  // ========================================
  assign det   = rt_pkg::dot_vec(src.e1, src.pvec);
  assign u_num = rt_pkg::dot_vec(src.tvec, src.pvec);
  assign v_num = rt_pkg::dot_vec(rt_pkg::ext_vec(src.dir), src.qvec);
  assign t_num = rt_pkg::dot_vec(src.e2, src.qvec);

  assign uv_sum = u_num + v_num;

  // Back faces are culled, so every test is done against a positive det
  always_comb begin
    hit = 1'b1;
    if (det <= 0) begin
      hit = 1'b0;
    end
    if (u_num < 0 || v_num < 0) begin
      hit = 1'b0;  // Outside across edge v0-v2 or v0-v1
    end
    if (uv_sum > det) begin
      hit = 1'b0;  // Outside across edge v1-v2
    end
    if (t_num <= 0) begin
      hit = 1'b0;  // Triangle lies behind the origin
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= start;
      if (start) begin
        result.hit   <= hit;
        result.det   <= det;
        result.t_num <= t_num;
        result.u_num <= u_num;
        result.v_num <= v_num;
        result.tag   <= src.tag;
      end
    end
  end

endmodule

// ==== rt_intersect.sv ====
module rt_intersect #(
  parameter int NUM_TRIANGLE = 512,
  parameter int NUM_THREAD   = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_done,
  input  rt_pkg::ray_tri_t    in_data,
  output logic                in_capture,
  input  logic                out_taken,
  output logic                out_capture,
  output rt_pkg::hit_result_t out_data
);

  localparam int BIT_TRIANGLE = $clog2(NUM_TRIANGLE);
  localparam int BIT_THREAD   = $clog2(NUM_THREAD);

  // Only the low id bits that this build uses are carried through
  localparam logic [rt_pkg::ID_W-1:0] TRIANGLE_MASK =
    {rt_pkg::ID_W{1'b1}} >> (rt_pkg::ID_W - BIT_TRIANGLE);
  localparam logic [rt_pkg::ID_W-1:0] THREAD_MASK =
    {rt_pkg::ID_W{1'b1}} >> (rt_pkg::ID_W - BIT_THREAD);

  rt_pkg::ray_tri_t    in_masked;
  rt_pkg::ray_tri_t    ray_q;
  rt_pkg::edge_pl_t    edge_d;
  rt_pkg::edge_pl_t    edge_q;
  rt_pkg::cross_pl_t   cross_d;
  rt_pkg::cross_pl_t   cross_q;
  rt_pkg::hit_result_t hit_d;
  rt_pkg::hit_result_t hit_q;

  logic cap_in;
  logic cap_edge;
  logic cap_cross;
  logic cap_out;
  logic done_edge;
  logic done_cross;
  logic done_hit;

  always_comb begin
    in_masked                 = in_data;
    in_masked.tag.thread_id   = in_data.tag.thread_id & THREAD_MASK;
    in_masked.tag.triangle_id = in_data.tag.triangle_id & TRIANGLE_MASK;
  end

  // ========================================
  // Stage chain
  // ========================================
  rt_stage_reg #(.payload_t(rt_pkg::ray_tri_t)) reg_in (
    .clk(clk), .rst(rst), .done(in_done), .next_capture(cap_edge),
    .data_in(in_masked), .capture(cap_in), .data_out(ray_q)
  );

  rt_edge_setup u_edge_setup (
    .clk(clk), .rst(rst), .start(cap_in), .src(ray_q),
    .done(done_edge), .result(edge_d)
  );

  rt_stage_reg #(.payload_t(rt_pkg::edge_pl_t)) reg_edge (
    .clk(clk), .rst(rst), .done(done_edge), .next_capture(cap_cross),
    .data_in(edge_d), .capture(cap_edge), .data_out(edge_q)
  );

  rt_cross_stage u_cross_stage (
    .clk(clk), .rst(rst), .start(cap_edge), .src(edge_q),
    .done(done_cross), .result(cross_d)
  );

  rt_stage_reg #(.payload_t(rt_pkg::cross_pl_t)) reg_cross (
    .clk(clk), .rst(rst), .done(done_cross), .next_capture(cap_out),
    .data_in(cross_d), .capture(cap_cross), .data_out(cross_q)
  );

  rt_hit_test u_hit_test (
    .clk(clk), .rst(rst), .start(cap_cross), .src(cross_q),
    .done(done_hit), .result(hit_d)
  );

  rt_stage_reg #(.payload_t(rt_pkg::hit_result_t)) reg_out (
    .clk(clk), .rst(rst), .done(done_hit), .next_capture(out_taken),
    .data_in(hit_d), .capture(cap_out), .data_out(hit_q)
  );

  assign in_capture  = cap_in;
  assign out_capture = cap_out;

  always_comb begin
    out_data                 = hit_q;
    out_data.tag.thread_id   = hit_q.tag.thread_id & THREAD_MASK;
    out_data.tag.triangle_id = hit_q.tag.triangle_id & TRIANGLE_MASK;
  end

endmodule

// ==== tb_rt_intersect.sv ====
module tb_rt_intersect;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TRIANGLE = 512;
  localparam int NUM_THREAD   = 32;
  localparam int N_CASES      = 10;
  localparam int N_RAND       = 40;
  localparam int N_REQ        = 1 + N_CASES + N_RAND;
  localparam int CYCLE_LIMIT  = 40 * N_REQ + 200;
  localparam int STALL_CYCLES = 30;
  localparam logic [15:0] THREAD_MASK   = 16'((1 << $clog2(NUM_THREAD)) - 1);
  localparam logic [15:0] TRIANGLE_MASK = 16'((1 << $clog2(NUM_TRIANGLE)) - 1);

  typedef struct packed {
    longint x;
    longint y;
    longint z;
  } lvec_t;

  logic                clk;
  logic                rst;
  logic                in_done;
  rt_pkg::ray_tri_t    in_data;
  logic                in_capture;
  logic                out_taken;
  logic                out_capture;
  rt_pkg::hit_result_t out_data;

  rt_pkg::hit_result_t exp_q [$];
  int          flag_q [$];  // Hit flag from the case table or -1 for a random request
  int          cyc = 0;
  int          n_results = 0;
  int          n_errors = 0;
  int          bp_errors = 0;
  int          n_checks = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          stall_at = -1;
  int          done_cyc;
  int          icap_cyc;
  int          ocap_cyc;
  logic [15:0] lfsr;

  // ========================================
  // Case table
  // ========================================
  // origin xyz, dir xyz, v0 xyz, v1 xyz, v2 xyz, expected hit
  int case_tab [N_CASES][16] = '{
    '{ 2, 2,  5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  1},  // Interior
    '{-3, 2,  5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  0},  // u_num < 0
    '{ 3,-2,  5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  0},  // v_num < 0
    '{ 6, 6,  5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  0},  // u + v > det
    '{ 2, 2, -5,  0, 0,  1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  0},  // Back face
    '{ 2, 2,  5,  1, 0,  0,     0,   0, 0,   10,   0, 0,     0,  10, 0,  0},  // Parallel
    '{ 2, 2, -5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  0},  // Behind
    '{ 0, 3,  5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  1},  // On edge
    '{ 5, 5,  5,  0, 0, -1,     0,   0, 0,   10,   0, 0,     0,  10, 0,  1},  // u + v = det
    '{ 0, 0,300,  1, 1,-10,  -100,-100, 7,  200,-100, 7,  -100, 200, 7,  1}
  };

  rt_intersect #(.NUM_TRIANGLE(NUM_TRIANGLE), .NUM_THREAD(NUM_THREAD)) UUT (
    .clk(clk), .rst(rst), .in_done(in_done), .in_data(in_data), .in_capture(in_capture),
    .out_taken(out_taken), .out_capture(out_capture), .out_data(out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic lvec_t widen(input rt_pkg::coord_vec_t c);
    return '{x: c.x, y: c.y, z: c.z};
  endfunction

  function automatic lvec_t minus(input lvec_t a, input lvec_t b);
    return '{x: a.x - b.x, y: a.y - b.y, z: a.z - b.z};
  endfunction

  function automatic lvec_t cross3(input lvec_t a, input lvec_t b);
    return '{x: a.y * b.z - a.z * b.y, y: a.z * b.x - a.x * b.z, z: a.x * b.y - a.y * b.x};
  endfunction

  function automatic longint dot3(input lvec_t a, input lvec_t b);
    return a.x * b.x + a.y * b.y + a.z * b.z;
  endfunction

  function automatic rt_pkg::hit_result_t expected_result(input rt_pkg::ray_tri_t r);
    lvec_t  v0;
    lvec_t  dir;
    lvec_t  e1;
    lvec_t  e2;
    lvec_t  tv;
    lvec_t  p;
    lvec_t  q;
    longint det;
    longint u;
    longint v;
    longint t;
    rt_pkg::hit_result_t res;
    v0  = widen(r.v0);
    dir = widen(r.dir);
    e1  = minus(widen(r.v1), v0);
    e2  = minus(widen(r.v2), v0);
    tv  = minus(widen(r.origin), v0);
    p   = cross3(dir, e2);
    q   = cross3(tv, e1);
    det = dot3(e1, p);
    u   = dot3(tv, p);
    v   = dot3(dir, q);
    t   = dot3(e2, q);
    res = '0;
    res.hit   = det > 0 && u >= 0 && v >= 0 && u + v <= det && t > 0;
    res.det   = det[rt_pkg::DOT_W-1:0];
    res.t_num = t[rt_pkg::DOT_W-1:0];
    res.u_num = u[rt_pkg::DOT_W-1:0];
    res.v_num = v[rt_pkg::DOT_W-1:0];
    res.tag   = r.tag;
    res.tag.thread_id   = r.tag.thread_id & THREAD_MASK;  // Only the ids the build carries
    res.tag.triangle_id = r.tag.triangle_id & TRIANGLE_MASK;
    return res;
  endfunction

  // ========================================
  // Stimulus
  // ========================================
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_signed(input int n, output int v);
    logic [31:0] b;
    int          k;
    b = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[30:0], lfsr[0]};
    end
    v = int'(b);
    if (b[n-1]) begin
      v = v - (1 << n);
    end
  endtask

  function automatic rt_pkg::ray_tri_t build_request(input int c [16], input logic [31:0] sid,
      input logic [15:0] tid, input logic [15:0] trid);
    rt_pkg::coord_vec_t v [5];
    rt_pkg::ray_tri_t   r;
    int                 k;
    for (k = 0; k < 5; k++) begin
      v[k] = {16'(c[3*k]), 16'(c[3*k+1]), 16'(c[3*k+2])};
    end
    r.origin          = v[0];
    r.dir             = v[1];
    r.v0              = v[2];
    r.v1              = v[3];
    r.v2              = v[4];
    r.tag.sid         = sid;
    r.tag.thread_id   = tid;
    r.tag.triangle_id = trid;
    return r;
  endfunction

  task automatic random_request(input int idx, output rt_pkg::ray_tri_t r);
    int c [16];
    int k;
    int jit;
    int tid;
    int trid;
    for (k = 0; k < 15; k++) begin
      take_signed(12, c[k]);
    end
    for (k = 0; k < 3; k++) begin
      take_signed(8, jit);
      c[3+k] = (c[6+k] + c[9+k] + c[12+k]) / 3 - c[k] + jit;  // Aim near the centroid
    end
    c[15] = 0;
    take_signed(16, tid);
    take_signed(16, trid);
    r = build_request(c, 32'h1000 + idx, 16'(tid), 16'(trid));
  endtask

  task automatic send_request(input rt_pkg::ray_tri_t req, input int flag);
    exp_q.push_back(expected_result(req));
    flag_q.push_back(flag);
    @(posedge clk);
    in_data <= req;
    in_done <= 1'b1;
    @(negedge clk);
    done_cyc = cyc;
    @(posedge clk);
    in_done <= 1'b0;
    // The input register may load later, so in_data is held until it does
    do begin
      @(negedge clk);
    end while (!in_capture);
    icap_cyc = cyc;
  endtask

  // ========================================
  // Checking
  // ========================================
  task automatic compare_field(input string name, input longint got, input longint want);
    n_checks++;
    if (got != want) begin
      $display("Fail at %0t ns: result %0d field %s is %0d, expected %0d",
               $time, n_results, name, got, want);
      n_errors++;
    end
  endtask

  task automatic check_result();
    rt_pkg::hit_result_t want;
    int                  flag;
    ocap_cyc = cyc;
    if (exp_q.size() == 0) begin
      $display("A result arrived at %0t ns with no request outstanding", $time);
      n_errors++;
    end else begin
      want = exp_q.pop_front();
      flag = flag_q.pop_front();
      compare_field("hit", out_data.hit, want.hit);
      compare_field("det", out_data.det, want.det);
      compare_field("t_num", out_data.t_num, want.t_num);
      compare_field("u_num", out_data.u_num, want.u_num);
      compare_field("v_num", out_data.v_num, want.v_num);
      compare_field("sid", out_data.tag.sid, want.tag.sid);
      compare_field("thread_id", out_data.tag.thread_id, want.tag.thread_id);
      compare_field("triangle_id", out_data.tag.triangle_id, want.tag.triangle_id);
      if (flag >= 0) begin
        compare_field("hit (case table)", out_data.hit, flag);
      end
    end
    n_results++;
  endtask

  task automatic check_idle();
    n_checks++;
    if (in_capture !== 1'b0 || out_capture !== 1'b0 || out_data !== '0) begin
      $display("Fail at %0t ns: reset state has in_capture=%b out_capture=%b out_data=%h",
               $time, in_capture, out_capture, out_data);
      n_errors++;
    end
  endtask

  // out_taken stays low here, so the whole pipeline backs up
  task automatic hold_output();
    int k;
    for (k = 1; k <= STALL_CYCLES; k++) begin
      @(negedge clk);
      if (out_capture) begin
        $display("A result was issued again at %0t ns before the last one was taken", $time);
        bp_errors++;
      end
      if (in_capture && k > STALL_CYCLES - 10) begin
        $display("in_capture still pulsed at %0t ns with the pipeline full", $time);
        bp_errors++;
      end
    end
  endtask

  task automatic wait_results(input int n);
    while (n_results < n) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  initial begin : consumer
    forever begin
      @(negedge clk);
      if (out_capture) begin
        check_result();
        if (n_results == stall_at) begin
          hold_output();
        end
        @(posedge clk);
        out_taken <= 1'b1;
        @(posedge clk);
        out_taken <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    while (cyc < CYCLE_LIMIT) begin
      @(negedge clk);
    end
    $display("Timeout after %0d cycles, %0d results still missing", cyc, N_REQ - n_results);
    $display("tests failed");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin : main
    int               err0;
    int               bp0;
    int               i;
    rt_pkg::ray_tri_t req;
    rst       = 1'b1;
    in_done   = 1'b0;
    in_data   = '0;
    out_taken = 1'b0;
    lfsr      = 16'd9584;

    err0 = n_errors;
    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
    report_test("reset_state", n_errors - err0);

    err0 = n_errors;
    send_request(build_request(case_tab[0], 32'h50, 16'h7, 16'h21), case_tab[0][15]);
    wait_results(1);
    if (icap_cyc - done_cyc != 1) begin
      $display("Fail at %0t ns: in_capture came %0d cycles after in_done, expected 1",
               $time, icap_cyc - done_cyc);
      n_errors++;
    end
    if (ocap_cyc - done_cyc != 8) begin
      $display("Fail at %0t ns: out_capture came %0d cycles after in_done, expected 8",
               $time, ocap_cyc - done_cyc);
      n_errors++;
    end
    report_test("latency", n_errors - err0);

    err0 = n_errors;
    for (i = 0; i < N_CASES; i++) begin
      req = build_request(case_tab[i], 32'h100 + i, 16'(40 + i), 16'(700 + i));
      send_request(req, case_tab[i][15]);
    end
    wait_results(1 + N_CASES);
    report_test("decision_rules", n_errors - err0);

    err0     = n_errors;
    bp0      = bp_errors;
    stall_at = n_results + N_RAND / 2;
    for (i = 0; i < N_RAND; i++) begin
      random_request(i, req);
      send_request(req, -1);
    end
    wait_results(N_REQ);
    repeat (20) @(negedge clk);
    report_test("streaming", n_errors - err0);
    if (n_results != N_REQ || exp_q.size() != 0) begin
      $display("%0d results arrived for %0d requests", n_results, N_REQ);
      bp_errors++;
    end
    report_test("back_pressure", bp_errors - bp0);

    $display("summary: %0d of %0d tests ok, %0d checks, %0d errors",
             tests_ok, tests_ok + tests_bad, n_checks, n_errors + bp_errors);
    if (tests_bad == 0 && n_errors + bp_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== rt_intersect.f ====
rt_pkg.sv
rt_stage_reg.sv
rt_edge_setup.sv
rt_cross_stage.sv
rt_hit_test.sv
rt_intersect.sv
tb_rt_intersect.sv
